//--- sim.f
uart_pkg.sv
baud_gen.sv
uart_tx.sv
uart_rx.sv
uart_regs.sv
wb_arbiter.sv
uart_top.sv
tb_uart_chk.sv
tb_uart.sv

//--- Makefile
VERILATOR := verilator
TOP       := tb_uart
FILELIST  := sim.f
FLAGS     := --binary --assert -j 0
SIM_ARGS  := +verilator+error+limit+100
OBJ_DIR   := obj_dir

SOURCES := $(shell cat $(FILELIST))

.PHONY: all lint clean

all: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS)

$(OBJ_DIR)/V$(TOP): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

lint:
	$(VERILATOR) --lint-only -Wall --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- tb_uart.sv
`timescale 1ns/10ps

module tb_uart import uart_pkg::*; ();

  localparam int CLK_PERIOD     = 8;
  localparam int CLK_DIV        = 8;
  localparam int NUM_ENTRIES    = 12;
  // Three frames per entry at most, plus slack for polling
  localparam int TIMEOUT_CYCLES = NUM_ENTRIES * 3 * UART_FRAME_BITS * CLK_DIV + 2000;
  // A held data write cannot finish before most of the running frame is out
  localparam time MIN_GAP = time'((UART_FRAME_BITS - 1) * CLK_DIV * CLK_PERIOD);
  localparam uart_status_t RX_ONLY    = uart_status_t'(1 << ST_RX_VALID);
  localparam uart_status_t RX_OVERRUN = uart_status_t'((1 << ST_RX_VALID) | (1 << ST_OVERRUN));

  typedef enum logic [1:0] {
    mode_solo,
    mode_simultaneous,
    mode_back_to_back
  } mode_e;

  typedef struct {
    int         port;
    uart_byte_t data;
    bit         rnd;
    mode_e      mode;
  } stim_t;

  // Port, byte, random flag, mode
  stim_t stim [NUM_ENTRIES] = '{
    '{0, 8'ha5, 1'b0, mode_solo},
    '{1, 8'h3c, 1'b0, mode_solo},
    '{0, 8'h00, 1'b1, mode_solo},
    '{1, 8'h00, 1'b1, mode_solo},
    '{0, 8'h00, 1'b0, mode_simultaneous},
    '{1, 8'hff, 1'b0, mode_simultaneous},
    '{0, 8'h00, 1'b1, mode_simultaneous},
    '{1, 8'h81, 1'b0, mode_simultaneous},
    '{0, 8'h5a, 1'b0, mode_back_to_back},
    '{1, 8'h00, 1'b1, mode_back_to_back},
    '{1, 8'h7e, 1'b0, mode_solo},
    '{0, 8'h01, 1'b0, mode_back_to_back}
  };

  logic        clk;
  logic        rstn;
  logic        line;
  wb_req_t     host_req [2];
  wb_rsp_t     host_rsp [2];
  time         ack_time [2];
  int          cycles;
  logic [31:0] lcg_state;
  wb_data_t    rd;

  // Serial output looped straight back into the receiver
  uart_top #(
    .CLK_DIV (CLK_DIV)
  ) uart_top_i (
    .clk       (clk),
    .rstn      (rstn),
    .host0_req (host_req[0]),
    .host1_req (host_req[1]),
    .host0_rsp (host_rsp[0]),
    .host1_rsp (host_rsp[1]),
    .rx        (line),
    .tx        (line)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1103515245 + 32'd12345;
  endfunction

  task automatic end_in_failure();
    $display("Test failed");
    $fatal(1, "simulation stopped after an error");
  endtask

  task automatic check_data(input wb_data_t got, input wb_data_t exp, input string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s, got %02h expected %02h", $time, what, got, exp);
      end_in_failure();
    end
  endtask

  task automatic check_status(input uart_status_t got, input uart_status_t exp,
                              input string what);
    if (got !== exp) begin
      $display("mismatch at %0t: %s, got %02h expected %02h", $time, what, got, exp);
      end_in_failure();
    end
  endtask

  // One classic cycle, request on a rising edge, ack sampled mid cycle
  task automatic bus_cycle(input int port, input logic we, input wb_addr_t adr,
                           input wb_data_t wdat, output wb_data_t rdat);
    wb_req_t req;
    req     = '0;
    req.cyc = 1'b1;
    req.stb = 1'b1;
    req.we  = we;
    req.adr = adr;
    req.dat = wdat;
    @(posedge clk);
    host_req[port] <= req;
    forever begin
      @(negedge clk);
      if (host_rsp[port].ack) break;
    end
    rdat           = host_rsp[port].dat;
    ack_time[port] = $time;
    @(posedge clk);
    host_req[port] <= '0;
  endtask

  task automatic wb_write(input int port, input wb_addr_t adr, input wb_data_t dat);
    wb_data_t unused;
    bus_cycle(port, 1'b1, adr, dat, unused);
  endtask

  task automatic wb_read(input int port, input wb_addr_t adr, output wb_data_t dat);
    bus_cycle(port, 1'b0, adr, '0, dat);
  endtask

  // Poll until the wanted bits are up and the transmitter is idle
  task automatic wait_status(input int port, input uart_status_t need,
                             output uart_status_t st);
    wb_data_t val;
    st = '0;
    while ((st & need) != need || st[ST_TX_BUSY]) begin
      wb_read(port, REG_STATUS, val);
      st = val;
    end
  endtask

  // Status, then the byte, then a clean status after the read
  task automatic collect(input int port, input uart_status_t need, input uart_byte_t exp);
    uart_status_t st;
    wb_data_t     val;
    wait_status(port, need, st);
    check_status(st, need, "status once the frame is back");
    wb_read(port, REG_DATA, val);
    check_data(val, exp, "received byte");
    wb_read(port, REG_STATUS, val);
    check_status(val, '0, "status after reading the byte");
  endtask

  task automatic run_solo(input int port, input uart_byte_t data);
    wb_write(port, REG_DATA, data);
    collect(port, RX_ONLY, data);
  endtask

  task automatic run_simultaneous(input int port, input uart_byte_t data);
    int           reader;
    wb_data_t     val;
    uart_status_t exp_st;
    reader = 1 - port;
    exp_st = '0;
    // Host 1 only gets the bus after host 0, so a write from host 0 is already sending
    if (reader == 1) begin
      exp_st[ST_TX_BUSY] = 1'b1;
    end
    fork
      wb_write(port, REG_DATA, data);
      wb_read(reader, REG_STATUS, val);
    join
    if (ack_time[0] >= ack_time[1]) begin
      $display("host 1 was acked before host 0 after requests in the same cycle");
      end_in_failure();
    end
    check_status(val, exp_st, "status read beside a data write");
    collect(port, RX_ONLY, data);
  endtask

  task automatic run_back_to_back(input int port, input uart_byte_t data);
    uart_byte_t second;
    time        t_first;
    second = ~data;
    wb_write(port, REG_DATA, data);
    t_first = ack_time[port];
    // Held off by tx busy until the first frame is out
    wb_write(port, REG_DATA, second);
    if (ack_time[port] - t_first < MIN_GAP) begin
      $display("second data write finished while the first frame was still being sent");
      end_in_failure();
    end
    // First byte never read, so the second one overruns it
    collect(port, RX_OVERRUN, second);
  endtask

  // Watchdog and checker monitor
  always @(posedge clk) begin
    cycles = cycles + 1;
    if (uart_top_i.tb_uart_chk_i.fail_count != 0) begin
      $display("an assertion of the bound checker failed before %0t", $time);
      end_in_failure();
    end else if (cycles >= TIMEOUT_CYCLES) begin
      $display("timeout, the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      end_in_failure();
    end
  end

  initial begin
    clk         = 1'b0;
    rstn        = 1'b0;
    host_req[0] = '0;
    host_req[1] = '0;
    cycles      = 0;
    lcg_state   = 32'd55;
    repeat (5) @(posedge clk);
    rstn <= 1'b1;
    wb_read(0, REG_STATUS, rd);
    check_status(rd, '0, "status after reset on port 0");
    wb_read(1, REG_STATUS, rd);
    check_status(rd, '0, "status after reset on port 1");
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (stim[i].rnd) begin
        lcg_state    = lcg_next(lcg_state);
        stim[i].data = lcg_state[23:16];
      end
      case (stim[i].mode)
        mode_solo:         run_solo(stim[i].port, stim[i].data);
        mode_simultaneous: run_simultaneous(stim[i].port, stim[i].data);
        mode_back_to_back: run_back_to_back(stim[i].port, stim[i].data);
        default:           run_solo(stim[i].port, stim[i].data);
      endcase
    end
    if (uart_top_i.tb_uart_chk_i.fail_count == 0) begin
      $display("Test passed");
      $finish;
    end else begin
      $display("an assertion of the bound checker failed during the last entry");
      end_in_failure();
    end
  end

endmodule

//--- tb_uart_chk.sv
`timescale 1ns/10ps

module tb_uart_chk import uart_pkg::*; (
  input logic    clk,
  input logic    rstn,
  input wb_req_t host0_req,
  input wb_req_t host1_req,
  input wb_rsp_t host0_rsp,
  input wb_rsp_t host1_rsp,
  input wb_req_t slv_req,
  input wb_rsp_t slv_rsp,
  input logic    tx
);

  int fail_count = 0;

  // Ack only inside the owner's open cycle
  ack_host0_open: assert property (@(posedge clk) disable iff (!rstn)
    host0_rsp.ack |-> host0_req.cyc && host0_req.stb)
  else begin
    $error("host 0 ack outside its cycle");
    fail_count++;
  end

  ack_host1_open: assert property (@(posedge clk) disable iff (!rstn)
    host1_rsp.ack |-> host1_req.cyc && host1_req.stb)
  else begin
    $error("host 1 ack outside its cycle");
    fail_count++;
  end

  ack_one_host: assert property (@(posedge clk) disable iff (!rstn)
    !(host0_rsp.ack && host1_rsp.ack))
  else begin
    $error("ack on both host ports");
    fail_count++;
  end

  // Idle line through reset and right after it
  tx_idle_reset: assert property (@(posedge clk)
    !rstn |=> tx)
  else begin
    $error("tx low around reset");
    fail_count++;
  end

  // Slave ack drops in the cycle after an acked strobe
  ack_single: assert property (@(posedge clk) disable iff (!rstn)
    slv_rsp.ack && slv_req.stb |=> !slv_rsp.ack)
  else begin
    $error("ack held for two cycles");
    fail_count++;
  end

endmodule

bind uart_top tb_uart_chk tb_uart_chk_i (
  .clk       (clk),
  .rstn      (rstn),
  .host0_req (host0_req),
  .host1_req (host1_req),
  .host0_rsp (host0_rsp),
  .host1_rsp (host1_rsp),
  .slv_req   (slv_req),
  .slv_rsp   (slv_rsp),
  .tx        (tx)
);

//--- uart_top.sv
`timescale 1ns/10ps

module uart_top import uart_pkg::*; #(
  parameter int CLK_DIV = 104
) (
  input  logic    clk,
  input  logic    rstn,
  input  wb_req_t host0_req,
  input  wb_req_t host1_req,
  output wb_rsp_t host0_rsp,
  output wb_rsp_t host1_rsp,
  input  logic    rx,
  output logic    tx
);

  wb_req_t    slv_req;
  wb_rsp_t    slv_rsp;
  logic       load;
  uart_byte_t tx_data;
  logic       tx_busy;
  logic       bit_tick;
  logic       rx_tick;
  logic       rx_sync;
  uart_byte_t rx_byte;
  logic       rx_done;
  logic       frame_err;

  // Two hosts share the register slave
  wb_arbiter wb_arbiter_i (
    .clk       (clk),
    .rstn      (rstn),
    .host0_req (host0_req),
    .host1_req (host1_req),
    .host0_rsp (host0_rsp),
    .host1_rsp (host1_rsp),
    .slv_req   (slv_req),
    .slv_rsp   (slv_rsp)
  );

  uart_regs uart_regs_i (
    .clk       (clk),
    .rstn      (rstn),
    .slv_req   (slv_req),
    .slv_rsp   (slv_rsp),
    .tx_busy   (tx_busy),
    .load      (load),
    .tx_data   (tx_data),
    .rx_byte   (rx_byte),
    .rx_done   (rx_done),
    .frame_err (frame_err)
  );

  // Transmit divider runs only while a frame is in flight
  baud_gen #(
    .CLK_DIV (CLK_DIV)
  ) baud_gen_i (
    .clk      (clk),
    .rstn     (rstn),
    .run      (tx_busy),
    .rx_sync  (rx_sync),
    .bit_tick (bit_tick),
    .rx_tick  (rx_tick)
  );

  uart_tx uart_tx_i (
    .clk      (clk),
    .rstn     (rstn),
    .load     (load),
    .tx_data  (tx_data),
    .bit_tick (bit_tick),
    .tx       (tx),
    .busy     (tx_busy)
  );

  uart_rx uart_rx_i (
    .clk       (clk),
    .rstn      (rstn),
    .rx        (rx),
    .rx_tick   (rx_tick),
    .rx_sync   (rx_sync),
    .rx_byte   (rx_byte),
    .rx_done   (rx_done),
    .frame_err (frame_err)
  );

endmodule

//--- wb_arbiter.sv
`timescale 1ns/10ps

module wb_arbiter import uart_pkg::*; (
  input  logic    clk,
  input  logic    rstn,
  input  wb_req_t host0_req,
  input  wb_req_t host1_req,
  output wb_rsp_t host0_rsp,
  output wb_rsp_t host1_rsp,
  output wb_req_t slv_req,
  input  wb_rsp_t slv_rsp
);

  typedef enum logic [1:0] {
    own_none,
    own_host0,
    own_host1
  } owner_e;

  owner_e owner;

  // Fixed priority, host 0 wins a tie
  always_ff @(posedge clk) begin
    if (!rstn) begin
      owner <= own_none;
    end else begin
      case (owner)
        own_none: begin
          if (host0_req.cyc) begin
            owner <= own_host0;
          end else if (host1_req.cyc) begin
            owner <= own_host1;
          end
        end
        // Bus stays with the owner until its cycle ends
        own_host0: if (!host0_req.cyc) owner <= own_none;
        own_host1: if (!host1_req.cyc) owner <= own_none;
        default:   owner <= own_none;
      endcase
    end
  end

  always_comb begin
    // Idle request when nobody owns the bus
    slv_req       = '0;
    host0_rsp     = slv_rsp;
    host1_rsp     = slv_rsp;
    host0_rsp.ack = 1'b0;
    host1_rsp.ack = 1'b0;
    case (owner)
      own_host0: begin
        slv_req       = host0_req;
        host0_rsp.ack = slv_rsp.ack;
      end
      own_host1: begin
        slv_req       = host1_req;
        host1_rsp.ack = slv_rsp.ack;
      end
      default: ;
    endcase
  end

endmodule

//--- uart_regs.sv
`timescale 1ns/10ps

module uart_regs import uart_pkg::*; (
  input  logic       clk,
  input  logic       rstn,
  input  wb_req_t    slv_req,
  output wb_rsp_t    slv_rsp,
  input  logic       tx_busy,
  output logic       load,
  output uart_byte_t tx_data,
  input  uart_byte_t rx_byte,
  input  logic       rx_done,
  input  logic       frame_err
);

  logic         ack_q;
  wb_data_t     dat_q;
  logic         rx_valid;
  logic         frame_err_q;
  logic         overrun;
  logic         req_ok;
  logic         data_wr;
  logic         data_rd;
  uart_status_t status;

  // No new request in the ack cycle, the master still holds it
  assign req_ok  = slv_req.cyc && slv_req.stb && !ack_q;
  assign data_wr = req_ok && slv_req.we && (slv_req.adr == REG_DATA);
  assign data_rd = req_ok && !slv_req.we && (slv_req.adr == REG_DATA);

  always_comb begin
    status               = '0;
    status[ST_TX_BUSY]   = tx_busy;
    status[ST_RX_VALID]  = rx_valid;
    status[ST_FRAME_ERR] = frame_err_q;
    status[ST_OVERRUN]   = overrun;
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      ack_q       <= 1'b0;
      load        <= 1'b0;
      rx_valid    <= 1'b0;
      frame_err_q <= 1'b0;
      overrun     <= 1'b0;
    end else begin
      ack_q <= 1'b0;
      load  <= 1'b0;
      // Data writes wait here while a frame is still going out
      if (data_wr) begin
        if (!tx_busy) begin
          ack_q <= 1'b1;
          load  <= 1'b1;
        end
      end else if (req_ok) begin
        ack_q <= 1'b1;
      end
      if (data_rd) begin
        rx_valid <= 1'b0;
        overrun  <= 1'b0;
      end
      // New byte wins over a read in the same cycle
      if (rx_done) begin
        rx_valid    <= 1'b1;
        frame_err_q <= frame_err;
        if (rx_valid && !data_rd) begin
          overrun <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (data_wr && !tx_busy) begin
      tx_data <= slv_req.dat;
    end
    if (req_ok && !slv_req.we) begin
      case (slv_req.adr)
        REG_DATA:   dat_q <= rx_byte;
        REG_STATUS: dat_q <= status;
        default:    dat_q <= '0;
      endcase
    end
  end

  assign slv_rsp.ack = ack_q;
  assign slv_rsp.dat = dat_q;

endmodule

//--- uart_rx.sv
`timescale 1ns/10ps

module uart_rx import uart_pkg::*; (
  input  logic       clk,
  input  logic       rstn,
  input  logic       rx,
  input  logic       rx_tick,
  output logic       rx_sync,
  output uart_byte_t rx_byte,
  output logic       rx_done,
  output logic       frame_err
);

  typedef enum logic [1:0] {
    rx_idle,
    rx_start,
    rx_data,
    rx_stop
  } rx_state_e;

  rx_state_e  state;
  // Two flop synchronizer plus a delayed copy for edge detection
  logic       rx_s1;
  logic       rx_s2;
  logic       rx_prev;
  logic [2:0] bit_idx;
  uart_byte_t shift;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      rx_s1   <= 1'b1;
      rx_s2   <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_s1   <= rx;
      rx_s2   <= rx_s1;
      rx_prev <= rx_s2;
    end
  end

  // Falling edge on an idle line restarts the sample phase
  assign rx_sync = (state == rx_idle) && rx_prev && !rx_s2;

  // Bits arrive LSB first
  always_ff @(posedge clk) begin
    if (state == rx_data && rx_tick) begin
      shift <= {rx_s2, shift[7:1]};
    end
    if (state == rx_stop && rx_tick) begin
      rx_byte <= shift;
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state     <= rx_idle;
      bit_idx   <= '0;
      rx_done   <= 1'b0;
      frame_err <= 1'b0;
    end else begin
      rx_done <= 1'b0;
      case (state)
        rx_idle: begin
          if (rx_sync) begin
            state <= rx_start;
          end
        end
        // A line back high at mid start was a glitch
        rx_start: begin
          if (rx_tick) begin
            bit_idx <= '0;
            state   <= rx_s2 ? rx_idle : rx_data;
          end
        end
        rx_data: begin
          if (rx_tick) begin
            bit_idx <= bit_idx + 1'b1;
            if (bit_idx == 3'd7) begin
              state <= rx_stop;
            end
          end
        end
        rx_stop: begin
          if (rx_tick) begin
            rx_done   <= 1'b1;
            // Low stop bit means a broken frame
            frame_err <= !rx_s2;
            state     <= rx_idle;
          end
        end
        default: state <= rx_idle;
      endcase
    end
  end

endmodule

//--- uart_tx.sv
`timescale 1ns/10ps

module uart_tx import uart_pkg::*; (
  input  logic       clk,
  input  logic       rstn,
  input  logic       load,
  input  uart_byte_t tx_data,
  input  logic       bit_tick,
  output logic       tx,
  output logic       busy
);

  typedef enum logic [1:0] {
    tx_idle,
    tx_loading,
    tx_sending
  } tx_state_e;

  tx_state_e  state;
  // Data bits plus the start bit in the LSB
  logic [8:0] shifter;
  // Bit times left in the frame
  logic [3:0] bitcount;

  // Shift right, ones enter from the top as stop bit and idle level
  always_ff @(posedge clk) begin
    if (state == tx_idle && load) begin
      shifter <= {tx_data, 1'b0};
    end else if (state == tx_loading || (state == tx_sending && bit_tick)) begin
      shifter <= {1'b1, shifter[8:1]};
    end
  end

  always_ff @(posedge clk) begin
    if (!rstn) begin
      state    <= tx_idle;
      tx       <= 1'b1;
      bitcount <= '0;
    end else begin
      case (state)
        tx_idle: begin
          tx <= 1'b1;
          if (load) begin
            bitcount <= 4'(UART_FRAME_BITS);
            state    <= tx_loading;
          end
        end
        // Start bit goes out right away, the divider starts with busy
        tx_loading: begin
          tx       <= shifter[0];
          bitcount <= bitcount - 1'b1;
          state    <= tx_sending;
        end
        tx_sending: begin
          if (bit_tick) begin
            // Count reaches zero once the stop bit has had its full time
            if (bitcount == '0) begin
              state <= tx_idle;
            end else begin
              tx       <= shifter[0];
              bitcount <= bitcount - 1'b1;
            end
          end
        end
        default: state <= tx_idle;
      endcase
    end
  end

  assign busy = (state != tx_idle);

endmodule

//--- baud_gen.sv
`timescale 1ns/10ps

module baud_gen #(
  parameter int CLK_DIV = 104
) (
  input  logic clk,
  input  logic rstn,
  input  logic run,
  input  logic rx_sync,
  output logic bit_tick,
  output logic rx_tick
);

  localparam int CW = (CLK_DIV > 2) ? $clog2(CLK_DIV) : 1;

  logic [CW-1:0] bit_cnt;
  logic [CW-1:0] rx_cnt;

  always_ff @(posedge clk) begin
    if (!rstn) begin
      bit_cnt <= '0;
      rx_cnt  <= '0;
    end else begin
      // Transmit divider only counts during a frame
      if (!run || bit_cnt == CW'(CLK_DIV - 1)) begin
        bit_cnt <= '0;
      end else begin
        bit_cnt <= bit_cnt + 1'b1;
      end
      // Receive divider, first tick lands half a bit after the start edge
      if (rx_sync) begin
        rx_cnt <= CW'(CLK_DIV / 2 - 1);
      end else if (rx_cnt == '0) begin
        rx_cnt <= CW'(CLK_DIV - 1);
      end else begin
        rx_cnt <= rx_cnt - 1'b1;
      end
    end
  end

  assign bit_tick = run && (bit_cnt == CW'(CLK_DIV - 1));
  // Free running between frames, the receiver ignores ticks while idle
  assign rx_tick  = (rx_cnt == '0);

endmodule

//--- uart_pkg.sv
package uart_pkg;

  // Serial payload byte
  typedef logic [7:0] uart_byte_t;

  // Register word address and bus data word
  typedef logic [1:0] wb_addr_t;
  typedef logic [7:0] wb_data_t;

  // Status word as seen on a read of REG_STATUS
  typedef logic [7:0] uart_status_t;

  // Master request, held until ack
  typedef struct packed {
    logic     cyc;
    logic     stb;
    logic     we;
    wb_addr_t adr;
    wb_data_t dat;
  } wb_req_t;

  // Slave response, ack lasts one cycle
  typedef struct packed {
    logic     ack;
    wb_data_t dat;
  } wb_rsp_t;

  // Register map
  localparam wb_addr_t REG_DATA   = 2'd0;
  localparam wb_addr_t REG_STATUS = 2'd1;

  // Status bit positions, upper bits read zero
  localparam int ST_TX_BUSY   = 0;
  localparam int ST_RX_VALID  = 1;
  localparam int ST_FRAME_ERR = 2;
  localparam int ST_OVERRUN   = 3;

  // Start bit, 8 data bits, stop bit
  localparam int UART_FRAME_BITS = 10;

endpackage
